/* hdl/z80_bus_pkg.sv */
package z80_bus_pkg;

    // kinds of machine cycle
    typedef logic [2:0] cycle_t;

    localparam cycle_t CYCLE_NONE = 3'd0;
    localparam cycle_t CYCLE_M1 = 3'd1;
    localparam cycle_t CYCLE_RDWR_MEM = 3'd2;
    localparam cycle_t CYCLE_RDWR_IO = 3'd3;
    localparam cycle_t CYCLE_INTERNAL = 3'd4;
    localparam cycle_t CYCLE_EXTENDED = 3'd5;

    // word offsets on the Wishbone port
    localparam logic [2:0] REG_ADDR = 3'd0;
    localparam logic [2:0] REG_DATA = 3'd1;
    localparam logic [2:0] REG_CMD = 3'd2;
    localparam logic [2:0] REG_STATUS = 3'd3;
    localparam logic [2:0] REG_REFRESH = 3'd4;

    typedef struct packed {
        logic [15:0] addr;
        logic mreq_n;
        logic iorq_n;
        logic rd_n;
        logic wr_n;
        logic m1_n;
        logic rfsh_n;
        logic [7:0] d_out;
        logic d_oe;
    } bus_pins_t;

    typedef struct packed {
        cycle_t cycle;
        logic [15:0] addr;
        logic [7:0] wdata;
        logic rd;
        logic wr;
        logic extend;
    } cycle_req_t;

    // command word as written to REG_CMD, cycle code in the low bits
    typedef struct packed {
        logic [3:0] extend_cnt;
        logic wr;
        logic rd;
        cycle_t cycle;
    } cmd_t;

    // status word as read from REG_STATUS
    typedef struct packed {
        logic busy;
        cycle_t cycle;
        logic [2:0] tcycle;
    } status_t;

    localparam bus_pins_t IDLE_PINS = '{
        addr: 16'h0000,
        mreq_n: 1'b1,
        iorq_n: 1'b1,
        rd_n: 1'b1,
        wr_n: 1'b1,
        m1_n: 1'b1,
        rfsh_n: 1'b1,
        d_out: 8'h00,
        d_oe: 1'b0
    };

endpackage

/* hdl/m1.sv */
// opcode fetch, T1-T2 read the opcode and T3-T4 put the refresh address out
module m1
    import z80_bus_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic activate,
    input logic [15:0] addr,
    input logic [15:0] refresh_addr,
    input logic [7:0] d_in,
    input logic wait_n,
    input logic extend_cycle,
    output bus_pins_t pins,
    output logic [7:0] rdata,
    output logic [2:0] tcycle,
    output logic extra_tcycle,
    output logic waitstated,
    output logic done
);

    logic [15:0] addr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            tcycle <= 3'd0;
        end else begin
            case (tcycle)
                3'd1: begin
                    tcycle <= 3'd2;
                end
                3'd2: begin
                    // a low wait_n repeats T2
                    if (wait_n) begin
                        tcycle <= 3'd3;
                    end
                end
                3'd3: begin
                    tcycle <= 3'd4;
                end
                3'd4: begin
                    if (!extend_cycle) begin
                        tcycle <= activate ? 3'd1 : 3'd0;
                    end
                end
                default: begin
                    tcycle <= activate ? 3'd1 : 3'd0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (activate) begin
            addr_q <= addr;
        end
        if (tcycle == 3'd2 && wait_n) begin
            rdata <= d_in;
        end
    end

    always_comb begin
        pins = IDLE_PINS;
        if (tcycle == 3'd1 || tcycle == 3'd2) begin
            pins.addr = addr_q;
            pins.mreq_n = 1'b0;
            pins.rd_n = 1'b0;
            pins.m1_n = 1'b0;
        end else if (tcycle == 3'd3 || tcycle == 3'd4) begin
            pins.addr = refresh_addr;
            pins.mreq_n = 1'b0;
            pins.rfsh_n = 1'b0;
        end
    end

    assign waitstated = (tcycle == 3'd2) && !wait_n;
    assign extra_tcycle = (tcycle == 3'd4) && extend_cycle;
    assign done = (tcycle == 3'd4);

endmodule

/* hdl/mrd_wr_mem.sv */
// memory read or write of three T-states, wait states go in after T2
module mrd_wr_mem
    import z80_bus_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic activate,
    input logic [15:0] addr,
    input logic [7:0] d_in,
    input logic [7:0] wdata,
    input logic rd,
    input logic wr,
    input logic wait_n,
    input logic extend_cycle,
    output bus_pins_t pins,
    output logic [7:0] rdata,
    output logic [2:0] tcycle,
    output logic extra_tcycle,
    output logic waitstated,
    output logic done
);

    logic [15:0] addr_q;
    logic [7:0] wdata_q;
    logic rd_q;
    logic wr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            tcycle <= 3'd0;
        end else begin
            case (tcycle)
                3'd1: begin
                    tcycle <= 3'd2;
                end
                3'd2: begin
                    if (wait_n) begin
                        tcycle <= 3'd3;
                    end
                end
                3'd3: begin
                    if (!extend_cycle) begin
                        tcycle <= activate ? 3'd1 : 3'd0;
                    end
                end
                default: begin
                    tcycle <= activate ? 3'd1 : 3'd0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (activate) begin
            addr_q <= addr;
            wdata_q <= wdata;
            rd_q <= rd;
            wr_q <= wr;
        end
        if (tcycle == 3'd2 && wait_n && rd_q) begin
            rdata <= d_in;
        end
    end

    always_comb begin
        pins = IDLE_PINS;
        if (tcycle != 3'd0) begin
            pins.addr = addr_q;
            pins.d_out = wdata_q;
            pins.d_oe = wr_q;
        end
        if (tcycle == 3'd1 || tcycle == 3'd2) begin
            pins.mreq_n = 1'b0;
            pins.rd_n = !rd_q;
            pins.wr_n = !wr_q;
        end
    end

    assign waitstated = (tcycle == 3'd2) && !wait_n;
    assign extra_tcycle = (tcycle == 3'd3) && extend_cycle;
    assign done = (tcycle == 3'd3);

endmodule

/* hdl/mrd_wr_io.sv */
// I/O read or write, iorq_n stays high in T1 and T3 is the automatic wait
module mrd_wr_io
    import z80_bus_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic activate,
    input logic [15:0] addr,
    input logic [7:0] d_in,
    input logic [7:0] wdata,
    input logic rd,
    input logic wr,
    input logic wait_n,
    output bus_pins_t pins,
    output logic [7:0] rdata,
    output logic [2:0] tcycle,
    output logic waitstated,
    output logic done
);

    logic [15:0] addr_q;
    logic [7:0] wdata_q;
    logic rd_q;
    logic wr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            tcycle <= 3'd0;
        end else begin
            case (tcycle)
                3'd1: begin
                    tcycle <= 3'd2;
                end
                3'd2: begin
                    tcycle <= 3'd3;
                end
                3'd3: begin
                    // wait_n is looked at only at the end of the automatic wait
                    if (wait_n) begin
                        tcycle <= 3'd4;
                    end
                end
                default: begin
                    tcycle <= activate ? 3'd1 : 3'd0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (activate) begin
            addr_q <= addr;
            wdata_q <= wdata;
            rd_q <= rd;
            wr_q <= wr;
        end
        if (tcycle == 3'd3 && wait_n && rd_q) begin
            rdata <= d_in;
        end
    end

    always_comb begin
        pins = IDLE_PINS;
        if (tcycle != 3'd0) begin
            pins.addr = addr_q;
            pins.d_out = wdata_q;
            pins.d_oe = wr_q;
        end
        if (tcycle == 3'd2 || tcycle == 3'd3) begin
            pins.iorq_n = 1'b0;
            pins.rd_n = !rd_q;
            pins.wr_n = !wr_q;
        end
    end

    assign waitstated = (tcycle == 3'd3) && !wait_n;
    assign done = (tcycle == 3'd4);

endmodule

/* hdl/mcycle.sv */
// starts the requested cycle once the running one is done and routes the
// pins of whichever cycle is active
module mcycle
    import z80_bus_pkg::*;
(
    input logic clk,
    input logic reset,
    input cycle_req_t req,
    input logic [15:0] refresh_addr,
    input logic [7:0] d_in,
    input logic wait_n,
    output bus_pins_t pins,
    output logic [7:0] rdata,
    output cycle_t cur_cycle,
    output logic [2:0] tcycle,
    output logic extra_tcycle,
    output logic m1_done,
    output logic done
);

    bus_pins_t pins_m1;
    bus_pins_t pins_mem;
    bus_pins_t pins_io;
    logic [7:0] rdata_m1;
    logic [7:0] rdata_mem;
    logic [7:0] rdata_io;
    logic [2:0] tc_m1;
    logic [2:0] tc_mem;
    logic [2:0] tc_io;
    logic [2:0] tc_int;
    logic extra_m1;
    logic extra_mem;
    logic done_m1;
    logic done_mem;
    logic done_io;
    logic done_sel;
    logic m1_active;
    logic mem_active;
    logic io_active;
    logic int_active;
    logic activate_int;
    cycle_t int_kind;

    assign m1_active = (tc_m1 != 3'd0);
    assign mem_active = (tc_mem != 3'd0);
    assign io_active = (tc_io != 3'd0);
    assign int_active = (tc_int != 3'd0);

    // internal and extended cycles drive no pins, so one counter serves both
    assign activate_int = done &&
        (req.cycle == CYCLE_INTERNAL || req.cycle == CYCLE_EXTENDED);

    always_ff @(posedge clk) begin
        if (reset) begin
            tc_int <= 3'd0;
            int_kind <= CYCLE_NONE;
        end else if (activate_int) begin
            tc_int <= 3'd1;
            int_kind <= req.cycle;
        end else if (int_active && req.extend) begin
            tc_int <= (tc_int == 3'd7) ? tc_int : tc_int + 3'd1;
        end else begin
            tc_int <= 3'd0;
        end
    end

    always_comb begin
        pins = IDLE_PINS;
        rdata = 8'h00;
        tcycle = tc_int;
        cur_cycle = int_active ? int_kind : CYCLE_NONE;
        extra_tcycle = int_active && req.extend;
        done_sel = 1'b1;
        if (m1_active) begin
            pins = pins_m1;
            rdata = rdata_m1;
            tcycle = tc_m1;
            cur_cycle = CYCLE_M1;
            extra_tcycle = extra_m1;
            done_sel = done_m1;
        end else if (mem_active) begin
            pins = pins_mem;
            rdata = rdata_mem;
            tcycle = tc_mem;
            cur_cycle = CYCLE_RDWR_MEM;
            extra_tcycle = extra_mem;
            done_sel = done_mem;
        end else if (io_active) begin
            pins = pins_io;
            rdata = rdata_io;
            tcycle = tc_io;
            cur_cycle = CYCLE_RDWR_IO;
            extra_tcycle = 1'b0;
            done_sel = done_io;
        end
    end

    // a pending extend keeps the current cycle from finishing
    assign done = !req.extend && done_sel;
    assign m1_done = m1_active && done;

    m1 u_m1 (
        .clk(clk),
        .reset(reset),
        .activate(done && req.cycle == CYCLE_M1),
        .addr(req.addr),
        .refresh_addr(refresh_addr),
        .d_in(d_in),
        .wait_n(wait_n),
        .extend_cycle(req.extend),
        .pins(pins_m1),
        .rdata(rdata_m1),
        .tcycle(tc_m1),
        .extra_tcycle(extra_m1),
        .waitstated(),
        .done(done_m1)
    );

    mrd_wr_mem u_mrd_wr_mem (
        .clk(clk),
        .reset(reset),
        .activate(done && req.cycle == CYCLE_RDWR_MEM),
        .addr(req.addr),
        .d_in(d_in),
        .wdata(req.wdata),
        .rd(req.rd),
        .wr(req.wr),
        .wait_n(wait_n),
        .extend_cycle(req.extend),
        .pins(pins_mem),
        .rdata(rdata_mem),
        .tcycle(tc_mem),
        .extra_tcycle(extra_mem),
        .waitstated(),
        .done(done_mem)
    );

    mrd_wr_io u_mrd_wr_io (
        .clk(clk),
        .reset(reset),
        .activate(done && req.cycle == CYCLE_RDWR_IO),
        .addr(req.addr),
        .d_in(d_in),
        .wdata(req.wdata),
        .rd(req.rd),
        .wr(req.wr),
        .wait_n(wait_n),
        .pins(pins_io),
        .rdata(rdata_io),
        .tcycle(tc_io),
        .waitstated(),
        .done(done_io)
    );

endmodule

/* hdl/bus_cmd_regs.sv */
// Wishbone register block, it holds one pending command for mcycle
module bus_cmd_regs
    import z80_bus_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic [2:0] wb_adr,
    input logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic wb_ack,
    input logic done,
    input logic [7:0] rdata,
    input logic m1_done,
    input logic extra_tcycle,
    input cycle_t cur_cycle,
    input logic [2:0] tcycle,
    output cycle_req_t req,
    output logic [15:0] refresh_addr
);

    logic [15:0] addr_q;
    logic [7:0] data_q;
    logic [7:0] i_q;
    logic [7:0] r_q;
    logic [3:0] ext_cnt;
    logic pending;
    logic run_rd;
    logic hold_cmd;
    logic wb_req;
    logic wr_en;
    logic accept;
    cmd_t cmd_q;
    cmd_t cmd_w;
    status_t status;

    assign cmd_w = wb_dat_w[$bits(cmd_t)-1:0];

    // a second command waits here until the first one has been taken
    assign hold_cmd = wb_we && (wb_adr == REG_CMD) && pending;
    assign wb_req = wb_cyc && wb_stb && !wb_ack && !hold_cmd;
    assign wr_en = wb_req && wb_we;
    assign accept = done && (req.cycle != CYCLE_NONE);

    always_comb begin
        req.cycle = pending ? cmd_q.cycle : CYCLE_NONE;
        req.addr = addr_q;
        req.wdata = data_q;
        req.rd = cmd_q.rd;
        req.wr = cmd_q.wr;
        req.extend = (ext_cnt != 4'd0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            cmd_q <= '0;
            pending <= 1'b0;
            run_rd <= 1'b0;
            ext_cnt <= 4'd0;
            i_q <= 8'h00;
            r_q <= 8'h00;
        end else begin
            wb_ack <= wb_req;
            if (wr_en && wb_adr == REG_CMD) begin
                cmd_q <= cmd_w;
                pending <= (cmd_w.cycle != CYCLE_NONE) && (cmd_w.cycle <= CYCLE_EXTENDED);
            end else if (accept) begin
                pending <= 1'b0;
            end
            if (accept) begin
                run_rd <= (req.cycle == CYCLE_M1) || (req.rd &&
                    (req.cycle == CYCLE_RDWR_MEM || req.cycle == CYCLE_RDWR_IO));
                // the I/O cycle has no extend phase
                ext_cnt <= (req.cycle == CYCLE_RDWR_IO) ? 4'd0 : cmd_q.extend_cnt;
            end else begin
                if (done) begin
                    run_rd <= 1'b0;
                end
                if (extra_tcycle) begin
                    ext_cnt <= ext_cnt - 4'd1;
                end
            end
            // only the low 7 bits of R count fetches
            if (wr_en && wb_adr == REG_REFRESH) begin
                i_q <= wb_dat_w[15:8];
                r_q <= wb_dat_w[7:0];
            end else if (m1_done) begin
                r_q[6:0] <= r_q[6:0] + 7'd1;
            end
        end
    end

    always_comb begin
        status.busy = pending || !done;
        status.cycle = cur_cycle;
        status.tcycle = tcycle;
    end

    always_ff @(posedge clk) begin
        if (done && run_rd) begin
            data_q <= rdata;
        end
        if (wr_en && wb_adr == REG_DATA) begin
            data_q <= wb_dat_w[7:0];
        end
        if (wr_en && wb_adr == REG_ADDR) begin
            addr_q <= wb_dat_w[15:0];
        end
        if (wb_req) begin
            case (wb_adr)
                REG_ADDR: wb_dat_r <= {16'h0000, addr_q};
                REG_DATA: wb_dat_r <= {24'h000000, data_q};
                REG_CMD: wb_dat_r <= 32'(cmd_q);
                REG_STATUS: wb_dat_r <= 32'(status);
                REG_REFRESH: wb_dat_r <= {16'h0000, i_q, r_q};
                default: wb_dat_r <= 32'h0000_0000;
            endcase
        end
    end

    assign refresh_addr = {i_q, r_q};

endmodule

/* hdl/z80_bus_unit.sv */
module z80_bus_unit
    import z80_bus_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic [2:0] wb_adr,
    input logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic wb_ack,
    output logic [15:0] addr,
    output logic mreq_n,
    output logic iorq_n,
    output logic rd_n,
    output logic wr_n,
    output logic m1_n,
    output logic rfsh_n,
    output logic [7:0] d_out,
    output logic d_oe,
    input logic [7:0] d_in,
    input logic wait_n
);

    cycle_req_t req;
    bus_pins_t pins;
    cycle_t cur_cycle;
    logic [15:0] refresh_addr;
    logic [7:0] rdata;
    logic [2:0] tcycle;
    logic extra_tcycle;
    logic m1_done;
    logic done;

    bus_cmd_regs u_regs (
        .clk(clk),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .done(done),
        .rdata(rdata),
        .m1_done(m1_done),
        .extra_tcycle(extra_tcycle),
        .cur_cycle(cur_cycle),
        .tcycle(tcycle),
        .req(req),
        .refresh_addr(refresh_addr)
    );

    mcycle u_mcycle (
        .clk(clk),
        .reset(reset),
        .req(req),
        .refresh_addr(refresh_addr),
        .d_in(d_in),
        .wait_n(wait_n),
        .pins(pins),
        .rdata(rdata),
        .cur_cycle(cur_cycle),
        .tcycle(tcycle),
        .extra_tcycle(extra_tcycle),
        .m1_done(m1_done),
        .done(done)
    );

    assign addr = pins.addr;
    assign mreq_n = pins.mreq_n;
    assign iorq_n = pins.iorq_n;
    assign rd_n = pins.rd_n;
    assign wr_n = pins.wr_n;
    assign m1_n = pins.m1_n;
    assign rfsh_n = pins.rfsh_n;
    assign d_out = pins.d_out;
    assign d_oe = pins.d_oe;

endmodule

/* dv/z80_bus_chk.sv */
// pin protocol rules of the Z80 bus as seen at z80_bus_unit
module z80_bus_chk
    import z80_bus_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic wait_n,
    input logic [15:0] addr,
    input logic mreq_n,
    input logic iorq_n,
    input logic rd_n,
    input logic wr_n,
    input logic m1_n,
    input logic rfsh_n,
    input logic [7:0] d_out,
    input logic d_oe,
    input logic wb_ack
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;
    bus_pins_t pins_now;

    assign pins_now = {addr, mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n, d_out, d_oe};

    m1_with_rd: assert property (@(posedge clk) disable iff (reset)
        !m1_n |-> !rd_n)
    else begin
        fail_count++;
        $error("m1_n is low while rd_n is high");
    end

    // refresh happens only in the second half of a fetch
    refresh_phase: assert property (@(posedge clk) disable iff (reset)
        !rfsh_n |-> (!mreq_n && m1_n))
    else begin
        fail_count++;
        $error("rfsh_n is low without mreq_n low and m1_n high");
    end

    mem_io_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(!mreq_n && !iorq_n))
    else begin
        fail_count++;
        $error("mreq_n and iorq_n are low together");
    end

    write_drives_bus: assert property (@(posedge clk) disable iff (reset)
        !wr_n |-> d_oe)
    else begin
        fail_count++;
        $error("wr_n is low while d_oe is low");
    end

    rd_held_by_wait: assert property (@(posedge clk) disable iff (reset)
        (!rd_n && !wait_n) |=> !rd_n)
    else begin
        fail_count++;
        $error("rd_n rose although wait_n was low");
    end

    wr_held_by_wait: assert property (@(posedge clk) disable iff (reset)
        (!wr_n && !wait_n) |=> !wr_n)
    else begin
        fail_count++;
        $error("wr_n rose although wait_n was low");
    end

    iorq_held_by_wait: assert property (@(posedge clk) disable iff (reset)
        (!iorq_n && !wait_n) |=> !iorq_n)
    else begin
        fail_count++;
        $error("iorq_n rose although wait_n was low");
    end

    idle_after_reset: assert property (@(posedge clk)
        reset |=> (pins_now == IDLE_PINS && !wb_ack))
    else begin
        fail_count++;
        $error("pins or wb_ack are not idle after reset");
    end

endmodule

bind z80_bus_unit z80_bus_chk chk (
    .clk(clk),
    .reset(reset),
    .wait_n(wait_n),
    .addr(addr),
    .mreq_n(mreq_n),
    .iorq_n(iorq_n),
    .rd_n(rd_n),
    .wr_n(wr_n),
    .m1_n(m1_n),
    .rfsh_n(rfsh_n),
    .d_out(d_out),
    .d_oe(d_oe),
    .wb_ack(wb_ack)
);

/* dv/z80_bus_unit_tb.sv */
module z80_bus_unit_tb
    import z80_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_FETCH = 8;
    localparam int N_PAIR = 6;
    localparam int N_REFRESH = 5;
    localparam int NUM_CMDS = 2 * (N_FETCH + 4 * N_PAIR) + N_REFRESH + 3;

    logic clk;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [2:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic wb_ack;
    logic [15:0] addr;
    logic mreq_n;
    logic iorq_n;
    logic rd_n;
    logic wr_n;
    logic m1_n;
    logic rfsh_n;
    logic [7:0] d_out;
    logic d_oe;
    logic [7:0] d_in;
    logic wait_n;

    integer seed = 13664;
    logic [7:0] mem_model [256];
    logic [7:0] io_model [256];
    logic wait_rand;
    logic quiet_exp;
    logic [7:0] wr_byte;
    logic [7:0] i_exp;
    logic [7:0] r_exp;
    int err_count = 0;
    int test_count = 0;
    int errs_before = 0;

    z80_bus_unit dut (.*);

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    function automatic int total_errors();
        return err_count + int'(dut.chk.fail_count);
    endfunction

    task automatic write_reg(input logic [2:0] adr, input logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = adr;
        wb_dat_w = data;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic read_reg(input logic [2:0] adr, output logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = adr;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
        data = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        assert (got === exp) else begin
            err_count++;
            $display("Mismatch at %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    // the command word is {extend count, wr, rd, cycle code} and busy is bit 6 of the status
    task automatic issue_cmd(input cycle_t cyc, input logic rd, input logic wr,
                             input logic [3:0] ext, input logic [15:0] a,
                             input logic [7:0] wd);
        logic [31:0] st;
        write_reg(REG_ADDR, {16'h0000, a});
        if (wr) begin
            write_reg(REG_DATA, {24'h000000, wd});
        end
        write_reg(REG_CMD, {23'd0, ext, wr, rd, cyc});
        do begin
            read_reg(REG_STATUS, st);
        end while (st[6]);
    endtask

    task automatic fetch_check(input logic [15:0] a, input logic [3:0] ext);
        logic [31:0] word;
        issue_cmd(CYCLE_M1, 1'b0, 1'b0, ext, a, 8'h00);
        read_reg(REG_DATA, word);
        compare_byte(word[7:0], mem_model[a[7:0]], "fetch");
        r_exp[6:0] = r_exp[6:0] + 7'd1;
    endtask

    task automatic mem_write_read(input logic [15:0] a, input logic [7:0] d);
        logic [31:0] word;
        wr_byte = d;
        issue_cmd(CYCLE_RDWR_MEM, 1'b0, 1'b1, 4'd0, a, d);
        compare_byte(mem_model[a[7:0]], d, "memory model after write");
        // the data register must not still hold the written byte when the read ends
        write_reg(REG_DATA, {24'h000000, ~d});
        issue_cmd(CYCLE_RDWR_MEM, 1'b1, 1'b0, 4'd0, a, 8'h00);
        read_reg(REG_DATA, word);
        compare_byte(word[7:0], d, "memory read-back");
    endtask

    task automatic io_write_read(input logic [15:0] a, input logic [7:0] d);
        logic [31:0] word;
        wr_byte = d;
        issue_cmd(CYCLE_RDWR_IO, 1'b0, 1'b1, 4'd0, a, d);
        compare_byte(io_model[a[7:0]], d, "I/O model after write");
        write_reg(REG_DATA, {24'h000000, ~d});
        issue_cmd(CYCLE_RDWR_IO, 1'b1, 1'b0, 4'd0, a, 8'h00);
        read_reg(REG_DATA, word);
        compare_byte(word[7:0], d, "I/O read-back");
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = total_errors() - errs_before;
        test_count++;
        $display("test %0d %s: %s (%0d errors)", test_count, name,
                 (errs == 0) ? "ok" : "FAILED", errs);
        errs_before = total_errors();
    endtask

    // the memory and I/O devices on the Z80 pins sample just after each edge
    always @(posedge clk) begin
        #1;
        wait_n = wait_rand ? (($random(seed) & 3) != 0) : 1'b1;
        if (!reset) begin
            if (!wr_n) begin
                assert (d_out === wr_byte) else begin
                    err_count++;
                    $display("Mismatch at %0t: d_out %02h expected %02h", $time, d_out, wr_byte);
                end
                if (!mreq_n) begin
                    mem_model[addr[7:0]] = d_out;
                end
                if (!iorq_n) begin
                    io_model[addr[7:0]] = d_out;
                end
            end
            if (!rfsh_n) begin
                assert (addr === {i_exp, r_exp}) else begin
                    err_count++;
                    $display("Mismatch at %0t: refresh address %04h expected %04h",
                             $time, addr, {i_exp, r_exp});
                end
            end
            if (quiet_exp) begin
                assert (mreq_n && iorq_n && rd_n && wr_n && m1_n && rfsh_n && !d_oe) else begin
                    err_count++;
                    $display("Strobe or d_oe active in an internal cycle at %0t", $time);
                end
            end
        end
        d_in = !iorq_n ? io_model[addr[7:0]] : mem_model[addr[7:0]];
    end

    initial begin
        repeat (NUM_CMDS * 400) @(posedge clk);
        $display("Timeout: no result after %0d clocks", NUM_CMDS * 400);
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [31:0] word;
        logic [7:0] r_start;
        for (int i = 0; i < 256; i++) begin
            mem_model[i] = 8'(i * 37 + 11);
            io_model[i] = 8'(i * 13) ^ 8'h5c;
        end
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 3'd0;
        wb_dat_w = 32'h0;
        d_in = 8'h00;
        wait_n = 1'b1;
        wait_rand = 1'b0;
        quiet_exp = 1'b0;
        wr_byte = 8'h00;
        i_exp = 8'h00;
        r_exp = 8'h00;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        assert (mreq_n && iorq_n && rd_n && wr_n && m1_n && rfsh_n && !d_oe && !wb_ack)
        else begin
            err_count++;
            $display("After reset a strobe, d_oe or wb_ack is still active at %0t", $time);
        end
        finish_test("reset_idle");

        for (int i = 0; i < N_FETCH; i++) begin
            fetch_check(16'($random(seed)), 4'd0);
        end
        finish_test("fetch");

        for (int i = 0; i < N_PAIR; i++) begin
            mem_write_read(16'($random(seed)), 8'($random(seed)));
        end
        finish_test("memory_write_read");

        for (int i = 0; i < N_PAIR; i++) begin
            io_write_read(16'($random(seed)), 8'($random(seed)));
        end
        finish_test("io_write_read");

        wait_rand = 1'b1;
        for (int i = 0; i < N_FETCH; i++) begin
            fetch_check(16'($random(seed)), 4'd0);
        end
        for (int i = 0; i < N_PAIR; i++) begin
            mem_write_read(16'($random(seed)), 8'($random(seed)));
            io_write_read(16'($random(seed)), 8'($random(seed)));
        end
        wait_rand = 1'b0;
        finish_test("random_wait");

        // start close to the top so that the low 7 bits wrap
        r_start = 8'hfc;
        i_exp = 8'($random(seed));
        write_reg(REG_REFRESH, {16'h0000, i_exp, r_start});
        r_exp = r_start;
        for (int i = 0; i < N_REFRESH; i++) begin
            fetch_check(16'($random(seed)), 4'd0);
        end
        read_reg(REG_REFRESH, word);
        compare_byte(word[7:0], {r_start[7], 7'(r_start[6:0] + N_REFRESH)}, "refresh R");
        compare_byte(word[15:8], i_exp, "refresh I");
        finish_test("refresh");

        quiet_exp = 1'b1;
        issue_cmd(CYCLE_INTERNAL, 1'b0, 1'b0, 4'd0, 16'h1234, 8'h00);
        issue_cmd(CYCLE_EXTENDED, 1'b0, 1'b0, 4'd3, 16'h4321, 8'h00);
        quiet_exp = 1'b0;
        fetch_check(16'($random(seed)), 4'd2);
        finish_test("internal_extended");

        $display("tests %0d, errors %0d", test_count, total_errors());
        if (total_errors() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/z80_bus_pkg.sv
hdl/m1.sv
hdl/mrd_wr_mem.sv
hdl/mrd_wr_io.sv
hdl/mcycle.sv
hdl/bus_cmd_regs.sv
hdl/z80_bus_unit.sv
dv/z80_bus_chk.sv
dv/z80_bus_unit_tb.sv
